// ==== hdl/pktgen_regs_pkg.sv ====
// host register map; word index is paddr[5:2], indices 14 and 15 are unmapped and flag an error
package pktgen_regs_pkg;

   // ----------------------------------------
   // word indices
   // ----------------------------------------
   typedef logic [3:0] reg_idx_t;                   // apb paddr[5:2]

   localparam reg_idx_t REG_NUMPKTS = 4'd0;         // frames per run, 0 runs until stop
   localparam reg_idx_t REG_RANDLEN = 4'd1;         // bit 0 selects random length
   localparam reg_idx_t REG_RANDPAY = 4'd2;         // bit 0 selects prbs payload
   localparam reg_idx_t REG_START   = 4'd3;         // write 1 to launch, reads 0
   localparam reg_idx_t REG_STOP    = 4'd4;         // level, honored at frame end
   localparam reg_idx_t REG_MACSA0  = 4'd5;         // source mac [31:0]
   localparam reg_idx_t REG_MACSA1  = 4'd6;         // source mac [47:32]
   localparam reg_idx_t REG_MACDA0  = 4'd7;         // destination mac [31:0]
   localparam reg_idx_t REG_MACDA1  = 4'd8;         // destination mac [47:32]
   localparam reg_idx_t REG_TXCNT   = 4'd9;         // frames sent, read only
   localparam reg_idx_t REG_SEED0   = 4'd10;        // prbs seed [31:0]
   localparam reg_idx_t REG_SEED1   = 4'd11;        // prbs seed [63:32]
   localparam reg_idx_t REG_SEED2   = 4'd12;        // prbs seed [91:64]
   localparam reg_idx_t REG_PKTLEN  = 4'd13;        // fixed frame size, highest mapped index

   // ----------------------------------------
   // field widths
   // ----------------------------------------
   localparam int APB_DATA_W = 32;
   localparam int PKTLEN_W   = 14;
   localparam int MAC_HI_W   = 16;                  // kept bits of MACSA1 / MACDA1
   localparam int SEED_HI_W  = 28;                  // kept bits of SEED2
   localparam int SEED_W     = 2 * APB_DATA_W + SEED_HI_W;

   // seed comes up non-zero so the prbs never locks at all zeros
   localparam logic [APB_DATA_W-1:0] SEED_RESET0 = 32'h5eed_0000;
   localparam logic [APB_DATA_W-1:0] SEED_RESET1 = 32'h5eed_0001;
   localparam logic [SEED_HI_W-1:0]  SEED_RESET2 = 28'h002_5eed;

endpackage

// ==== hdl/eth_frame_pkg.sv ====
// frame layout on the 64-bit stream; no fcs is generated, the downstream mac appends it
package eth_frame_pkg;

   // ----------------------------------------
   // stream word
   // ----------------------------------------
   localparam int BEAT_BYTES = 8;
   typedef logic [8*BEAT_BYTES-1:0] beat_t;         // first byte in bits 63:56
   typedef logic [2:0]              empty_t;        // unused bytes at the tail of eop beat
   typedef logic [15:0]             len_t;          // payload byte count
   typedef logic [47:0]             mac_t;

   // ----------------------------------------
   // length rules
   // ----------------------------------------
   localparam int FRAME_OVERHEAD = 24;              // header bytes taken off the frame size
   localparam int MAX_FRAME      = 9600;            // jumbo clamp
   localparam int RAND_LEN_MOD   = 1495;

   // what the output register takes next
   typedef enum logic [1:0] {
      bk_none,                                      // nothing, valid drops
      bk_addr,                                      // da + sa[47:32], carries sop
      bk_hdr,                                       // sa[31:0] + length + sequence
      bk_data                                       // payload
   } beat_kind_t;

   // ----------------------------------------
   // prbs23, x^23 + x^18 + 1
   // ----------------------------------------
   localparam int PRBS_W   = 23;
   localparam int PRBS_TAP = 18;
   localparam int PRBS_LEN_LSB = 64;                // random length source bits
   localparam int PRBS_LEN_MSB = 74;

endpackage

// ==== hdl/pktgen_cfg_if.sv ====
// configuration from the register block to the datapath; start is a single-cycle pulse
`timescale 1ns/1ps

interface pktgen_cfg_if;

   logic                                    start;           // one clk wide
   logic                                    stop;            // level
   logic [pktgen_regs_pkg::APB_DATA_W-1:0]  num_packets;     // 0 = endless
   logic                                    random_length;
   logic                                    random_payload;
   logic [pktgen_regs_pkg::PKTLEN_W-1:0]    pkt_length;      // frame size in bytes
   eth_frame_pkg::mac_t                     mac_da;
   eth_frame_pkg::mac_t                     mac_sa;
   logic [pktgen_regs_pkg::SEED_W-1:0]      seed;
   logic [pktgen_regs_pkg::APB_DATA_W-1:0]  tx_count;        // back from the sequencer

   modport regs (
      output start, stop, num_packets, random_length, random_payload,
      output pkt_length, mac_da, mac_sa, seed,
      input  tx_count
   );
   modport seq   (input start, stop, num_packets, output tx_count);
   modport build (input random_length, random_payload, pkt_length, mac_da, mac_sa);
   modport prbs  (input seed);

endinterface

// ==== hdl/pktgen_regs.sv ====
// apb slave with no wait states; writes land on the access edge, unmapped indices give pslverr
`timescale 1ns/1ps

module pktgen_regs (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic [5:0]                             paddr,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [pktgen_regs_pkg::APB_DATA_W-1:0] pwdata,
   output logic [pktgen_regs_pkg::APB_DATA_W-1:0] prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   pktgen_cfg_if.regs                             cfg
);

   localparam int W  = pktgen_regs_pkg::APB_DATA_W;
   localparam int MH = pktgen_regs_pkg::MAC_HI_W;
   localparam int SH = pktgen_regs_pkg::SEED_HI_W;

   pktgen_regs_pkg::reg_idx_t idx;
   logic                      access;               // apb access phase
   logic                      wr;

   assign idx     = paddr[5:2];
   assign access  = psel & penable;
   assign wr      = access & pwrite;
   assign pready  = 1'b1;                           // zero wait states
   assign pslverr = access & (idx > pktgen_regs_pkg::REG_PKTLEN);

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg.start          <= 1'b0;
         cfg.stop           <= 1'b0;
         cfg.num_packets    <= '0;
         cfg.random_length  <= 1'b0;
         cfg.random_payload <= 1'b0;
         cfg.pkt_length     <= '0;
         cfg.mac_sa         <= '0;
         cfg.mac_da         <= '0;
         cfg.seed           <= {pktgen_regs_pkg::SEED_RESET2, pktgen_regs_pkg::SEED_RESET1,
                                pktgen_regs_pkg::SEED_RESET0};
      end else begin
         // self clearing, so a held 1 still gives a single pulse
         cfg.start <= wr & (idx == pktgen_regs_pkg::REG_START) & pwdata[0];
         if (wr) begin
            case (idx)
               pktgen_regs_pkg::REG_NUMPKTS: cfg.num_packets    <= pwdata;
               pktgen_regs_pkg::REG_RANDLEN: cfg.random_length  <= pwdata[0];
               pktgen_regs_pkg::REG_RANDPAY: cfg.random_payload <= pwdata[0];
               pktgen_regs_pkg::REG_STOP:    cfg.stop           <= pwdata[0];
               pktgen_regs_pkg::REG_MACSA0:  cfg.mac_sa[W-1:0]   <= pwdata;
               pktgen_regs_pkg::REG_MACSA1:  cfg.mac_sa[W +: MH] <= pwdata[MH-1:0];
               pktgen_regs_pkg::REG_MACDA0:  cfg.mac_da[W-1:0]   <= pwdata;
               pktgen_regs_pkg::REG_MACDA1:  cfg.mac_da[W +: MH] <= pwdata[MH-1:0];
               pktgen_regs_pkg::REG_SEED0:   cfg.seed[W-1:0]     <= pwdata;
               pktgen_regs_pkg::REG_SEED1:   cfg.seed[W +: W]    <= pwdata;
               pktgen_regs_pkg::REG_SEED2:   cfg.seed[2*W +: SH] <= pwdata[SH-1:0];
               pktgen_regs_pkg::REG_PKTLEN:
                  cfg.pkt_length <= pwdata[pktgen_regs_pkg::PKTLEN_W-1:0];
               default: ;                           // start, txcnt and holes
            endcase
         end
      end
   end

   // ----------------------------------------
   // read mux, straight from the registers
   // ----------------------------------------
   always_comb begin
      case (idx)
         pktgen_regs_pkg::REG_NUMPKTS: prdata = cfg.num_packets;
         pktgen_regs_pkg::REG_RANDLEN: prdata = W'(cfg.random_length);
         pktgen_regs_pkg::REG_RANDPAY: prdata = W'(cfg.random_payload);
         pktgen_regs_pkg::REG_STOP:    prdata = W'(cfg.stop);
         pktgen_regs_pkg::REG_MACSA0:  prdata = cfg.mac_sa[W-1:0];
         pktgen_regs_pkg::REG_MACSA1:  prdata = W'(cfg.mac_sa[W +: MH]);   // upper half reads 0
         pktgen_regs_pkg::REG_MACDA0:  prdata = cfg.mac_da[W-1:0];
         pktgen_regs_pkg::REG_MACDA1:  prdata = W'(cfg.mac_da[W +: MH]);
         pktgen_regs_pkg::REG_TXCNT:   prdata = cfg.tx_count;
         pktgen_regs_pkg::REG_SEED0:   prdata = cfg.seed[W-1:0];
         pktgen_regs_pkg::REG_SEED1:   prdata = cfg.seed[W +: W];
         pktgen_regs_pkg::REG_SEED2:   prdata = W'(cfg.seed[2*W +: SH]);
         pktgen_regs_pkg::REG_PKTLEN:  prdata = W'(cfg.pkt_length);
         default:                      prdata = '0;  // start reads back 0
      endcase
   end

endmodule

// ==== hdl/pktgen_seq.sv ====
// frame sequencer; start is taken only in idle, stop and the packet limit act after a last beat
`timescale 1ns/1ps

module pktgen_seq (
   input  logic                      clk,
   input  logic                      reset,
   pktgen_cfg_if.seq                 cfg,
   input  logic                      tx_ready,
   input  logic                      last_beat,     // from the builder
   output eth_frame_pkg::beat_kind_t kind,          // beat to load on the next update
   output logic                      accept,        // presented beat transfers
   output logic                      load_len,      // latch payload length
   output eth_frame_pkg::len_t       seq_num
);

   typedef enum logic [2:0] {s_idle, s_load, s_addr, s_hdr, s_data, s_gap} state_t;

   state_t state;
   state_t state_nxt;
   logic   presenting;                              // a beat sits on the stream port
   logic   done;                                    // run ends at this frame boundary

   assign presenting = (state == s_addr) | (state == s_hdr) | (state == s_data);
   assign accept     = presenting & tx_ready;
   assign load_len   = (state == s_load);
   assign done       = cfg.stop |
                       ((cfg.num_packets != '0) & (cfg.tx_count == cfg.num_packets));

   // ----------------------------------------
   // next state and next beat
   // ----------------------------------------
   always_comb begin
      state_nxt = state;
      kind      = eth_frame_pkg::bk_none;           // valid drops in idle and gap
      case (state)
         s_idle: if (cfg.start) state_nxt = s_load;
         s_load: begin
            kind      = eth_frame_pkg::bk_addr;
            state_nxt = s_addr;
         end
         s_addr: begin
            kind = eth_frame_pkg::bk_hdr;
            if (accept) state_nxt = s_hdr;
         end
         s_hdr, s_data: begin                       // empty payload ends on the header
            if (!last_beat) kind = eth_frame_pkg::bk_data;
            if (accept) state_nxt = last_beat ? s_gap : s_data;
         end
         s_gap:   state_nxt = done ? s_idle : s_load;
         default: state_nxt = s_idle;
      endcase
   end

   // ----------------------------------------
   // state, sequence number, frames sent
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state        <= s_idle;
         seq_num      <= '0;
         cfg.tx_count <= '0;
      end else begin
         state <= state_nxt;
         if (cfg.start) begin
            seq_num      <= '0;
            cfg.tx_count <= '0;
         end else if (accept & last_beat) begin // count at frame end
            seq_num      <= seq_num + 1'b1;
            cfg.tx_count <= cfg.tx_count + 1'b1;
         end
      end
   end

endmodule

// ==== hdl/prbs_gen.sv ====
// independent prbs23 lanes jumping 23 serial steps per advance; an all-zero seed lane stays zero
`timescale 1ns/1ps

module prbs_gen #(
   parameter int LANES = 4
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    load,      // take the seed
   input  logic                                    advance,   // one jump per beat
   input  logic [eth_frame_pkg::PRBS_W*LANES-1:0] seed,
   output logic [eth_frame_pkg::PRBS_W*LANES-1:0] prbs
);

   localparam int W = eth_frame_pkg::PRBS_W;

   // 23 right shifts of x^23 + x^18 + 1 unrolled
   function automatic logic [W-1:0] jump(input logic [W-1:0] s);
      logic [W-1:0] t;
      t = s;
      for (int i = 0; i < W; i++) begin
         t = {t[eth_frame_pkg::PRBS_TAP] ^ t[0], t[W-1:1]};   // new msb from taps 18 and 0
      end
      return t;
   endfunction

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         prbs <= '0;
      end else if (load) begin
         prbs <= seed;
      end else if (advance) begin
         for (int l = 0; l < LANES; l++) begin
            prbs[l*W +: W] <= jump(prbs[l*W +: W]);
         end
      end
   end

endmodule

// ==== hdl/frame_builder.sv ====
// registered stream source; outputs hold while tx_ready is low, bytes past the payload are filler
`timescale 1ns/1ps

module frame_builder (
   input  logic                                  clk,
   input  logic                                  reset,
   pktgen_cfg_if.build                           cfg,
   input  eth_frame_pkg::beat_kind_t             kind,
   input  logic                                  accept,
   input  logic                                  load_len,
   input  eth_frame_pkg::len_t                   seq_num,
   input  logic [eth_frame_pkg::PRBS_LEN_MSB:0]  prbs,
   input  logic                                  tx_ready,
   output logic                                  last_beat,
   output eth_frame_pkg::beat_t                  tx_data,
   output logic                                  tx_valid,
   output logic                                  tx_sop,
   output logic                                  tx_eop,
   output eth_frame_pkg::empty_t                 tx_empty
);

   localparam int NB = eth_frame_pkg::BEAT_BYTES;

   eth_frame_pkg::len_t   frame_sz;
   eth_frame_pkg::len_t   len_nxt;                  // payload length for the coming frame
   eth_frame_pkg::len_t   len_q;
   eth_frame_pkg::len_t   remain;                   // bytes from the next data beat on
   logic [7:0]            pay_idx;                  // first byte of the next data beat
   eth_frame_pkg::beat_t  inc_word;
   eth_frame_pkg::empty_t last_empty;
   logic                  upd;                      // output register may change
   logic                  step;                     // a data beat is being loaded
   logic                  data_last;

   assign upd        = ~tx_valid | tx_ready;
   assign step       = accept & (kind == eth_frame_pkg::bk_data);
   assign data_last  = remain <= eth_frame_pkg::len_t'(NB);
   assign last_empty = 3'd0 - len_q[2:0];           // (8 - L mod 8) mod 8
   assign last_beat  = tx_eop;
   assign frame_sz   = eth_frame_pkg::len_t'(cfg.pkt_length);

   // ----------------------------------------
   // payload length and pattern
   // ----------------------------------------
   always_comb begin
      if (cfg.random_length) begin
         len_nxt = eth_frame_pkg::len_t'(prbs[eth_frame_pkg::PRBS_LEN_MSB:
                                               eth_frame_pkg::PRBS_LEN_LSB]) %
                   eth_frame_pkg::len_t'(eth_frame_pkg::RAND_LEN_MOD);
      end else if (frame_sz < eth_frame_pkg::len_t'(eth_frame_pkg::FRAME_OVERHEAD)) begin
         len_nxt = '0;                              // header only
      end else if (frame_sz > eth_frame_pkg::len_t'(eth_frame_pkg::MAX_FRAME)) begin
         len_nxt = eth_frame_pkg::len_t'(eth_frame_pkg::MAX_FRAME -
                                         eth_frame_pkg::FRAME_OVERHEAD);
      end else begin
         len_nxt = frame_sz - eth_frame_pkg::len_t'(eth_frame_pkg::FRAME_OVERHEAD);
      end
   end

   always_comb begin
      for (int b = 0; b < NB; b++) begin            // byte k carries k mod 256
         inc_word[8*(NB-1-b) +: 8] = pay_idx + 8'(b);
      end
   end

   // ----------------------------------------
   // counters and stream control
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         len_q    <= '0;
         remain   <= '0;
         pay_idx  <= '0;
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else begin
         if (load_len) begin
            len_q   <= len_nxt;
            remain  <= len_nxt;
            pay_idx <= '0;
         end else if (step) begin
            remain  <= remain - eth_frame_pkg::len_t'(NB);
            pay_idx <= pay_idx + 8'(NB);
         end
         if (upd) begin
            tx_valid <= kind != eth_frame_pkg::bk_none;
            tx_sop   <= kind == eth_frame_pkg::bk_addr;
            tx_eop   <= ((kind == eth_frame_pkg::bk_hdr) & (len_q == '0)) |
                        ((kind == eth_frame_pkg::bk_data) & data_last);
            tx_empty <= ((kind == eth_frame_pkg::bk_data) & data_last) ? last_empty : '0;
         end
      end
   end

   // data word, holds through the gap
   always_ff @(posedge clk) begin
      if (upd) begin
         case (kind)
            eth_frame_pkg::bk_addr: tx_data <= {cfg.mac_da, cfg.mac_sa[47:32]};
            eth_frame_pkg::bk_hdr:  tx_data <= {cfg.mac_sa[31:0], len_q, seq_num};
            eth_frame_pkg::bk_data: tx_data <= cfg.random_payload ? prbs[63:0] : inc_word;
            default: ;
         endcase
      end
   end

endmodule

// ==== hdl/pktgen_top.sv ====
// packet generator top; apb and stream share clk, reset is asynchronous and active high
`timescale 1ns/1ps

module pktgen_top (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic [5:0]                             paddr,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [pktgen_regs_pkg::APB_DATA_W-1:0] pwdata,
   output logic [pktgen_regs_pkg::APB_DATA_W-1:0] prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   input  logic                                   tx_ready,
   output eth_frame_pkg::beat_t                   tx_data,
   output logic                                   tx_valid,
   output logic                                   tx_sop,
   output logic                                   tx_eop,
   output eth_frame_pkg::empty_t                  tx_empty
);

   localparam int LANES = 4;                        // 4 x 23 covers the 92-bit seed

   eth_frame_pkg::beat_kind_t                   kind;
   logic                                        accept;
   logic                                        load_len;
   logic                                        last_beat;
   logic                                        prbs_step;
   eth_frame_pkg::len_t                         seq_num;
   logic [eth_frame_pkg::PRBS_W*LANES-1:0]      prbs_word;

   pktgen_cfg_if cfg ();

   // every transfer except the address beat, whose next kind is the header
   assign prbs_step = accept & (kind != eth_frame_pkg::bk_hdr);

   pktgen_regs u_regs (
      .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr, .cfg (cfg.regs)
   );

   pktgen_seq u_seq (
      .clk, .reset, .cfg (cfg.seq), .tx_ready, .last_beat,
      .kind, .accept, .load_len, .seq_num
   );

   prbs_gen #(.LANES (LANES)) u_prbs (
      .clk, .reset, .load (cfg.start), .advance (prbs_step),
      .seed (cfg.seed), .prbs (prbs_word)
   );

   frame_builder u_build (
      .clk, .reset, .cfg (cfg.build), .kind, .accept, .load_len, .seq_num,
      .prbs (prbs_word[eth_frame_pkg::PRBS_LEN_MSB:0]), .tx_ready, .last_beat,
      .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

endmodule

// ==== tests/pktgen_tb.sv ====
// testbench for pktgen_top; expects one shared clock, frames are checked once each run has ended
`timescale 1ns/1ps

module pktgen_tb;

   // beats of tests 2 to 6, random lengths taken at their largest
   localparam int EXPECT_BEATS = 14 + (3 + 2 + 1199) + 14 + 3 * (2 + 187) + 30;
   localparam int WATCH_CYCLES = EXPECT_BEATS * 4 + 2000;
   localparam logic [47:0] MAC_DA    = 48'h0011_2233_4455;
   localparam logic [47:0] MAC_SA    = 48'ha1b2_c3d4_e5f6;
   localparam logic [91:0] PRBS_SEED = {28'h0ab_cdef, 32'h0123_4567, 32'h89ab_cdef};

   logic        clk = 1'b0;
   logic        reset;
   logic [5:0]  paddr;
   logic        psel, penable, pwrite;
   logic [31:0] pwdata, prdata;
   logic        pready, pslverr;
   logic        tx_ready, tx_valid, tx_sop, tx_eop;
   logic [63:0] tx_data;
   logic [2:0]  tx_empty;

   logic [68:0] obs[$];                             // {sop, eop, empty, data} per transfer
   logic [68:0] ref_beats[$];                       // test 2 run, replayed under back-pressure
   logic [68:0] held_beat;
   logic        held;
   logic        bp_on = 1'b0;
   logic [31:0] rnd;
   integer      rand_seed = 32'hdc62;
   int          eop_count = 0;
   int          errors = 0;
   int          tests_run = 0;

   always #4 clk = ~clk;                            // 8 ns period

   pktgen_top uut (.*);

   // ----------------------------------------
   // sink and monitor
   // ----------------------------------------
   always @(negedge clk) begin
      if (bp_on) begin
         rnd      = $random(rand_seed);
         tx_ready = rnd[0];                         // about half the cycles stall
      end else begin
         tx_ready = 1'b1;
      end
   end

   always @(posedge clk) begin
      if (held) begin                               // last edge stalled a valid beat
         assert (tx_valid && {tx_sop, tx_eop, tx_empty, tx_data} == held_beat)
            else report_mismatch("stream outputs moved while tx_ready was low");
      end
      held      = !reset && tx_valid && !tx_ready;
      held_beat = {tx_sop, tx_eop, tx_empty, tx_data};
      if (!reset && tx_valid && tx_ready) begin
         obs.push_back({tx_sop, tx_eop, tx_empty, tx_data});
         if (tx_eop) eop_count++;
      end
   end

   initial begin
      repeat (WATCH_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the generator stopped responding",
               WATCH_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   // ----------------------------------------
   // reporting
   // ----------------------------------------
   task automatic report_mismatch(input string msg);
      errors++;
      $display("[FAIL] %0d ns: %s", $time, msg);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic finish_test(input int num, input string name, input int mark);
      tests_run++;
      if (errors == mark) $display("test %0d %s: ok", num, name);
      else $display("test %0d %s: %0d failures", num, name, errors - mark);
   endtask

   // ----------------------------------------
   // apb master, driven on the falling edge
   // ----------------------------------------
   task automatic apb_access(input logic wr, input pktgen_regs_pkg::reg_idx_t idx,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(negedge clk);                               // setup phase
      paddr   = {idx, 2'b00};
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;                               // access, no wait states
      @(negedge clk);
      rdata   = prdata;
      err     = pslverr;
      assert (pready) else report_mismatch("pready was low in the access phase");
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic reg_write(input pktgen_regs_pkg::reg_idx_t idx, input logic [31:0] d);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, idx, d, rd, err);
   endtask

   task automatic read_expect(input pktgen_regs_pkg::reg_idx_t idx, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b0, idx, '0, rd, err);
      assert (rd == exp && !err)
         else report_mismatch($sformatf("register %0d read %h, expected %h", idx, rd, exp));
   endtask

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   // each 23-bit lane, 23 serial steps of x^23 + x^18 + 1
   function automatic logic [91:0] prbs_next(input logic [91:0] p);
      logic [22:0] lane;
      logic        fb;
      for (int l = 0; l < 4; l++) begin
         lane = p[l*23 +: 23];
         repeat (23) begin
            fb   = lane[18] ^ lane[0];
            lane = {fb, lane[22:1]};
         end
         p[l*23 +: 23] = lane;
      end
      return p;
   endfunction

   task automatic compare_beat(input int idx, input logic [68:0] exp, input int nbytes);
      logic [68:0] mask;
      mask = {5'h1f, {64{1'b1}} << (8 * (8 - nbytes))};   // bytes past the payload ignored
      if (idx >= obs.size())
         report_problem($sformatf("beat %0d of the run was never transferred", idx));
      else
         assert ((obs[idx] & mask) == (exp & mask))
            else report_mismatch($sformatf("beat %0d: got %h, expected %h", idx, obs[idx], exp));
   endtask

   task automatic check_frames(input int nframes, input int pktlen, input logic rlen,
                               input logic rpay, input logic [91:0] start_state);
      logic [91:0] p;
      logic [63:0] word;
      logic [2:0]  empty;
      logic        last;
      int          pos, len, nbeat;
      p   = start_state;
      pos = 0;
      for (int f = 0; f < nframes; f++) begin
         if (rlen) len = int'(p[74:64]) % 1495;
         else if (pktlen < 24) len = 0;
         else len = (pktlen > 9600 ? 9600 : pktlen) - 24;
         nbeat = (len + 7) / 8;
         compare_beat(pos, {1'b1, 1'b0, 3'd0, MAC_DA, MAC_SA[47:32]}, 8);
         pos++;
         compare_beat(pos, {1'b0, len == 0, 3'd0, MAC_SA[31:0], 16'(len), 16'(f)}, 8);
         pos++;
         for (int i = 0; i < nbeat; i++) begin
            last  = (i == nbeat - 1);
            empty = last ? 3'((8 - len % 8) % 8) : 3'd0;
            if (rpay) begin
               word = p[63:0];
            end else begin
               for (int b = 0; b < 8; b++) word[8*(7-b) +: 8] = 8'((8 * i + b) % 256);
            end
            compare_beat(pos, {1'b0, last, empty, word}, 8 - empty);
            pos++;
            p = prbs_next(p);                       // one step per data beat
         end
         p = prbs_next(p);                          // and one for the header
      end
      assert (obs.size() == pos)
         else report_problem($sformatf("run gave %0d beats instead of %0d", obs.size(), pos));
   endtask

   task automatic run_frames(input int npkts, input int pktlen, input logic rlen,
                             input logic rpay);
      int n;
      reg_write(pktgen_regs_pkg::REG_NUMPKTS, npkts);
      reg_write(pktgen_regs_pkg::REG_PKTLEN, pktlen);
      reg_write(pktgen_regs_pkg::REG_RANDLEN, rlen);
      reg_write(pktgen_regs_pkg::REG_RANDPAY, rpay);
      obs.delete();
      eop_count = 0;
      reg_write(pktgen_regs_pkg::REG_START, 32'd1);
      while (eop_count < npkts) @(negedge clk);
      n = obs.size();
      repeat (20) @(negedge clk);                   // must have gone idle by now
      assert (obs.size() == n && !tx_valid)
         else report_problem("generator kept sending after its packet count was reached");
      read_expect(pktgen_regs_pkg::REG_TXCNT, npkts);
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------
   initial begin
      int          mark;
      logic [31:0] rd;
      logic        err;
      reset = 1'b1;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      tx_ready = 1'b1;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      mark = errors;
      read_expect(pktgen_regs_pkg::REG_SEED0, pktgen_regs_pkg::SEED_RESET0);
      read_expect(pktgen_regs_pkg::REG_SEED1, pktgen_regs_pkg::SEED_RESET1);
      read_expect(pktgen_regs_pkg::REG_SEED2, 32'(pktgen_regs_pkg::SEED_RESET2));
      reg_write(pktgen_regs_pkg::REG_MACSA0, MAC_SA[31:0]);
      reg_write(pktgen_regs_pkg::REG_MACSA1, {16'hdead, MAC_SA[47:32]});  // junk on top
      reg_write(pktgen_regs_pkg::REG_MACDA0, MAC_DA[31:0]);
      reg_write(pktgen_regs_pkg::REG_MACDA1, {16'hbeef, MAC_DA[47:32]});
      reg_write(pktgen_regs_pkg::REG_SEED0, PRBS_SEED[31:0]);
      reg_write(pktgen_regs_pkg::REG_SEED1, PRBS_SEED[63:32]);
      reg_write(pktgen_regs_pkg::REG_SEED2, {4'hf, PRBS_SEED[91:64]});
      reg_write(pktgen_regs_pkg::REG_PKTLEN, 32'd1234);
      read_expect(pktgen_regs_pkg::REG_MACSA0, MAC_SA[31:0]);
      read_expect(pktgen_regs_pkg::REG_MACSA1, {16'h0, MAC_SA[47:32]});
      read_expect(pktgen_regs_pkg::REG_MACDA0, MAC_DA[31:0]);
      read_expect(pktgen_regs_pkg::REG_MACDA1, {16'h0, MAC_DA[47:32]});
      read_expect(pktgen_regs_pkg::REG_SEED0, PRBS_SEED[31:0]);
      read_expect(pktgen_regs_pkg::REG_SEED1, PRBS_SEED[63:32]);
      read_expect(pktgen_regs_pkg::REG_SEED2, {4'h0, PRBS_SEED[91:64]});
      read_expect(pktgen_regs_pkg::REG_PKTLEN, 32'd1234);
      read_expect(pktgen_regs_pkg::REG_START, 32'd0);
      apb_access(1'b0, 4'd15, '0, rd, err);
      assert (err) else report_mismatch("index 15 gave no pslverr");
      finish_test(1, "register access", mark);

      mark = errors;
      run_frames(2, 64, 1'b0, 1'b0);
      check_frames(2, 64, 1'b0, 1'b0, PRBS_SEED);
      ref_beats = obs;
      finish_test(2, "fixed length frames", mark);

      mark = errors;
      run_frames(1, 27, 1'b0, 1'b0);                // 3 payload bytes
      check_frames(1, 27, 1'b0, 1'b0, PRBS_SEED);
      run_frames(1, 20, 1'b0, 1'b0);                // header only
      check_frames(1, 20, 1'b0, 1'b0, PRBS_SEED);
      run_frames(1, 12000, 1'b0, 1'b0);             // clamped jumbo
      check_frames(1, 12000, 1'b0, 1'b0, PRBS_SEED);
      finish_test(3, "odd, empty and clamped lengths", mark);

      mark = errors;
      bp_on = 1'b1;
      run_frames(2, 64, 1'b0, 1'b0);
      bp_on = 1'b0;
      check_frames(2, 64, 1'b0, 1'b0, PRBS_SEED);
      assert (obs.size() == ref_beats.size())
         else report_problem("back-pressure changed the number of beats transferred");
      foreach (ref_beats[i]) begin
         if (i < obs.size())
            assert (obs[i] == ref_beats[i])
               else report_mismatch($sformatf("beat %0d differs from the run without stalls", i));
      end
      finish_test(4, "back-pressure", mark);

      mark = errors;
      run_frames(3, 64, 1'b1, 1'b1);
      check_frames(3, 0, 1'b1, 1'b1, PRBS_SEED);
      finish_test(5, "random length and payload", mark);

      mark = errors;
      reg_write(pktgen_regs_pkg::REG_NUMPKTS, 32'd0);       // endless until stop
      reg_write(pktgen_regs_pkg::REG_PKTLEN, 32'd128);      // 15 beats per frame
      reg_write(pktgen_regs_pkg::REG_RANDLEN, 32'd0);
      reg_write(pktgen_regs_pkg::REG_RANDPAY, 32'd0);
      obs.delete();
      eop_count = 0;
      reg_write(pktgen_regs_pkg::REG_START, 32'd1);
      while (obs.size() < 16) @(negedge clk);               // second frame under way
      reg_write(pktgen_regs_pkg::REG_STOP, 32'd1);
      while (eop_count < 2) @(negedge clk);
      repeat (40) @(negedge clk);
      assert (obs.size() == 30 && eop_count == 2)
         else report_problem("a new frame started after stop was written");
      check_frames(2, 128, 1'b0, 1'b0, PRBS_SEED);
      read_expect(pktgen_regs_pkg::REG_TXCNT, 32'd2);
      finish_test(6, "stop", mark);

      $display("%0d tests run, %0d failures", tests_run, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== pktgen.f ====
hdl/pktgen_regs_pkg.sv
hdl/eth_frame_pkg.sv
hdl/pktgen_cfg_if.sv
hdl/pktgen_regs.sv
hdl/pktgen_seq.sv
hdl/prbs_gen.sv
hdl/frame_builder.sv
hdl/pktgen_top.sv
tests/pktgen_tb.sv

// ==== Bender.yml ====
package:
  name: pktgen

sources:
  - hdl/pktgen_regs_pkg.sv
  - hdl/eth_frame_pkg.sv
  - hdl/pktgen_cfg_if.sv
  - hdl/pktgen_regs.sv
  - hdl/pktgen_seq.sv
  - hdl/prbs_gen.sv
  - hdl/frame_builder.sv
  - hdl/pktgen_top.sv
  - target: test
    files:
      - tests/pktgen_tb.sv
